// File: list.f
common/ata_pkg.sv
common/host_pkg.sv
ide/ide_cycle.sv
ide/ide_req_queue.sv
source/ide_host.sv
sim/ata_disk_model.sv
sim/ide_host_properties.sv
sim/ide_host_tb.sv

// File: run.sh
#!/bin/sh
# build and run the IDE host testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module ide_host_tb -o ide_host_sim

./obj_dir/ide_host_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: sim/ide_host_tb.sv
/*
 * testbench for the IDE host: clock, reset, credit-counting host,
 * stimulus table checked against shadow registers, latency check
 */
`timescale 1ns/1ps
`default_nettype none

module ide_host_tb
   import ata_pkg::*, host_pkg::*;
();

   localparam logic [3:0] strobe_cycles = 4'd2;
   localparam int         queue_depth   = 4;
   localparam int         wait_limit    = 200;   // cycles before a wait gives up
   localparam ata_addr_t  status_reg    = 5'b10_111;

   typedef struct packed {
      logic        write;
      ata_addr_t   addr;
      logic [15:0] wdata;
      logic [15:0] rdata;   // expected on reads
      logic        err;     // expected device_error after a read
   } step_t;

   logic        clk;
   logic        reset;
   logic        req_valid;
   ide_req_t    req;
   logic        credit_return;
   logic        rsp_valid;
   ide_rsp_t    rsp;
   logic        device_error;
   logic [15:0] ide_data_in;
   logic [15:0] ide_data_out;
   logic        ide_dior;
   logic        ide_diow;
   logic [1:0]  ide_cs;
   logic [2:0]  ide_da;

   step_t       table_q[$];
   step_t       exp_q[$];
   step_t       head;
   logic [15:0] shadow [32];
   logic        err_model;
   logic        err_pending;
   logic        err_expected;
   int          credits;
   int          pushes;
   int          returns;
   int          errors;
   int          timeouts;
   int          checks;
   int          cycle_no;
   int          last_return;
   int          last_latency;
   int          seed;
   bit          hung;

   ide_host #(
      .strobe_cycles (strobe_cycles),
      .queue_depth   (queue_depth)
   ) ide_host_i (.*);

   ata_disk_model disk_i (.*);

   always #20 clk = ~clk;

   task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic add_write(input ata_addr_t a, input logic [15:0] d);
      table_q.push_back('{write: 1'b1, addr: a, wdata: d, rdata: 16'h0, err: err_model});
      shadow[a] = d;
   endtask

   task automatic add_read(input ata_addr_t a);
      if (a == status_reg)
         err_model = shadow[a][0];   // err is bit 0 of the status byte
      table_q.push_back('{write: 1'b0, addr: a, wdata: 16'h0, rdata: shadow[a], err: err_model});
   endtask

   task automatic build_table();
      ata_addr_t a;
      add_write(5'b01_000, 16'h1234);
      add_read(5'b01_000);
      add_read(5'b01_101);                 // never written
      // burst past one credit
      add_write(5'b01_001, 16'ha5a5);
      add_write(5'b01_010, 16'h5a5a);
      add_write(5'b01_011, 16'hffff);
      add_write(5'b10_010, 16'hc0de);
      add_read(5'b01_001);
      add_read(5'b01_010);
      add_read(5'b01_011);
      add_read(5'b10_010);
      // status err raises and clears the flag
      add_write(status_reg, 16'h0051);
      add_read(status_reg);
      add_read(5'b01_000);                 // data read leaves it alone
      add_write(status_reg, 16'h0050);
      add_read(status_reg);
      for (int c = 1; c <= 2; c++) begin
         for (int d = 0; d < 8; d++) begin
            a.cs = 2'(c);
            a.da = 3'(d);
            add_write(a, 16'($random(seed)));
         end
      end
      for (int c = 1; c <= 2; c++) begin
         for (int d = 0; d < 8; d++) begin
            a.cs = 2'(c);
            a.da = 3'(d);
            add_read(a);
         end
      end
      add_read(5'b01_000);                 // isolated read for the latency check
   endtask

   // one clock of host activity, credits counted from the settled pulse
   task automatic step_host(input logic push, input ide_req_t r);
      @(posedge clk);
      req_valid <= push;
      if (push)
         req <= r;
      @(negedge clk);
      if (credit_return)
         credits++;
   endtask

   task automatic issue(input step_t s);
      int waited;
      waited = 0;
      while (credits == 0 && waited < wait_limit) begin
         step_host(1'b0, req);
         waited++;
      end
      if (credits == 0) begin
         $display("timeout at %0t ns: no credit came back for a waiting request", $time);
         timeouts++;
         hung = 1'b1;
      end else begin
         credits--;
         pushes++;
         if (!s.write)
            exp_q.push_back(s);
         step_host(1'b1, '{write: s.write, addr: s.addr, wdata: s.wdata});
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while ((credits != queue_depth || exp_q.size() != 0) && waited < wait_limit) begin
         step_host(1'b0, req);
         waited++;
      end
      if (credits != queue_depth || exp_q.size() != 0) begin
         $display("timeout at %0t ns: queue or responses did not drain", $time);
         timeouts++;
         hung = 1'b1;
      end
      repeat (8) step_host(1'b0, req);   // last bus cycle and recovery
   endtask

   //////////////////////////////////////////////////
   // response monitor, sampled mid-cycle

   always @(negedge clk) begin
      cycle_no++;
      if (credit_return) begin
         returns++;
         last_return = cycle_no;
      end
      if (err_pending) begin
         check("device_error", 16'(device_error), 16'(err_expected));
         err_pending = 1'b0;
      end
      if (rsp_valid) begin
         last_latency = cycle_no - last_return;
         if (exp_q.size() == 0) begin
            errors++;
            $display("read response at %0t ns with no read outstanding", $time);
         end else begin
            head = exp_q.pop_front();
            check("response address", 16'(rsp.addr), 16'(head.addr));
            check("read data", rsp.rdata.raw, head.rdata);
            err_pending  = 1'b1;
            err_expected = head.err;
         end
      end
   end

   //////////////////////////////////////////////////
   // main sequence

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      req_valid   = 1'b0;
      req         = '0;
      credits     = queue_depth;
      err_model   = 1'b0;
      err_pending = 1'b0;
      seed        = 32'h5a5e;
      for (int i = 0; i < 32; i++)
         shadow[i] = 16'h0000;
      build_table();

      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check("dior after reset", 16'(ide_dior), 16'd1);
      check("diow after reset", 16'(ide_diow), 16'd1);
      check("cs after reset", 16'(ide_cs), 16'h3);
      check("rsp_valid after reset", 16'(rsp_valid), 16'd0);
      check("device_error after reset", 16'(device_error), 16'd0);

      for (int i = 0; i < table_q.size() && !hung; i++) begin
         if (i == table_q.size() - 1)
            drain();                       // empty queue and idle engine first
         if (!hung)
            issue(table_q[i]);
      end
      if (!hung)
         drain();
      if (!hung) begin
         check("read latency", 16'(last_latency), 16'(strobe_cycles + 3));
         check("credits returned", 16'(returns), 16'(pushes));
      end

      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/ide_host_properties.sv
/*
 * concurrent checks on IDE strobes, idle bus levels and queue overflow,
 * bound into the cycle engine and the request queue
 */
`timescale 1ns/1ps
`default_nettype none

module ide_host_properties #(
   parameter int depth = 4
) (
   input logic       clk,
   input logic       reset,
   input logic       ide_dior,
   input logic       ide_diow,
   input logic [1:0] ide_cs,
   input logic [2:0] ide_da,
   input logic       cycle_active,
   input logic       strobe_active,
   input logic       push,
   input int         count
);

   strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
      ide_dior || ide_diow)
      else $error("dior and diow asserted together");

   bus_parked: assert property (@(posedge clk) disable iff (reset)
      !cycle_active && !strobe_active |-> ide_cs == 2'b11 && ide_da == 3'b111)
      else $error("cs or da not parked while idle");

   no_overflow: assert property (@(posedge clk) disable iff (reset)
      push |-> count < depth)
      else $error("request pushed into a full queue");

endmodule

// engine instance with the queue inputs tied quiet
bind ide_cycle ide_host_properties cycle_props_i (
   .clk(clk), .reset(reset), .ide_dior(ide_dior), .ide_diow(ide_diow),
   .ide_cs(ide_cs), .ide_da(ide_da), .cycle_active(cycle_active),
   .strobe_active(strobe_active), .push(1'b0), .count(0)
);

// queue instance with the bus inputs at their parked levels
bind ide_req_queue ide_host_properties #(.depth(queue_depth)) queue_props_i (
   .clk(clk), .reset(reset), .ide_dior(1'b1), .ide_diow(1'b1),
   .ide_cs(2'b11), .ide_da(3'b111), .cycle_active(1'b0),
   .strobe_active(1'b0), .push(req_valid), .count(int'(count))
);

`default_nettype wire

// File: sim/ata_disk_model.sv
/*
 * behavioral IDE device: 32 task-file registers indexed by {cs, da},
 * written on the falling write strobe and read while dior is low
 */
`timescale 1ns/1ps
`default_nettype none

module ata_disk_model (
   input  logic [15:0] ide_data_out,
   output logic [15:0] ide_data_in,
   input  logic        ide_dior,
   input  logic        ide_diow,
   input  logic [1:0]  ide_cs,
   input  logic [2:0]  ide_da
);

   logic [15:0] regs [32];

   // device powers up with every register cleared
   initial begin
      for (int i = 0; i < 32; i++)
         regs[i] = 16'h0000;
   end

   always @(negedge ide_diow)
      regs[{ide_cs, ide_da}] <= ide_data_out;   // address is stable since setup

   assign ide_data_in = ide_dior ? 16'h0000 : regs[{ide_cs, ide_da}];

endmodule

`default_nettype wire

// File: source/ide_host.sv
/*
 * IDE host top: request queue feeding the PIO cycle engine
 */
`timescale 1ns/1ps
`default_nettype none

module ide_host
   import host_pkg::*;
#(
   parameter logic [3:0] strobe_cycles = 4'd15,
   parameter int         queue_depth   = 4
) (
   input  logic        clk,
   input  logic        reset,

   // host side
   input  logic        req_valid,
   input  ide_req_t    req,
   output logic        credit_return,
   output logic        rsp_valid,
   output ide_rsp_t    rsp,
   output logic        device_error,

   // IDE bus, data split in and out
   input  logic [15:0] ide_data_in,
   output logic [15:0] ide_data_out,
   output logic        ide_dior,
   output logic        ide_diow,
   output logic [1:0]  ide_cs,
   output logic [2:0]  ide_da
);

   logic     cyc_valid;
   logic     cyc_take;
   ide_req_t cyc_req;

   //////////////////////////////////////////////////
   // pending requests

   ide_req_queue #(
      .queue_depth   (queue_depth)
   ) ide_req_queue_i (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (req_valid),
      .req           (req),
      .cyc_take      (cyc_take),
      .cyc_valid     (cyc_valid),
      .cyc_req       (cyc_req),
      .credit_return (credit_return)
   );

   //////////////////////////////////////////////////
   // bus cycle engine

   ide_cycle #(
      .strobe_cycles (strobe_cycles)
   ) ide_cycle_i (
      .clk           (clk),
      .reset         (reset),
      .cyc_valid     (cyc_valid),
      .cyc_req       (cyc_req),
      .cyc_take      (cyc_take),
      .rsp_valid     (rsp_valid),
      .rsp           (rsp),
      .device_error  (device_error),
      .ide_data_in   (ide_data_in),
      .ide_data_out  (ide_data_out),
      .ide_dior      (ide_dior),
      .ide_diow      (ide_diow),
      .ide_cs        (ide_cs),
      .ide_da        (ide_da)
   );

endmodule

`default_nettype wire

// File: ide/ide_req_queue.sv
/*
 * request FIFO in front of the cycle engine,
 * one credit returned to the host per entry handed over
 */
`timescale 1ns/1ps
`default_nettype none

module ide_req_queue
   import host_pkg::*;
#(
   parameter int queue_depth = 4   // entries, also the host's starting credits
) (
   input  logic     clk,
   input  logic     reset,

   input  logic     req_valid,
   input  ide_req_t req,

   input  logic     cyc_take,
   output logic     cyc_valid,
   output ide_req_t cyc_req,

   output logic     credit_return
);

   localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
   localparam int cnt_w = $clog2(queue_depth + 1);
   localparam logic [ptr_w-1:0] last_slot = ptr_w'(queue_depth - 1);

   ide_req_t         mem [queue_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;   // occupied entries
   logic             pop;

   // pointer step with wrap for any depth
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
      return (ptr == last_slot) ? '0 : ptr + 1'b1;
   endfunction

   assign pop = cyc_take && cyc_valid;

   //////////////////////////////////////////////////
   // storage

   always_ff @(posedge clk) begin
      if (req_valid)
         mem[wr_ptr] <= req;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (req_valid)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({req_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle, or push and pop together
         endcase
      end
   end

   //////////////////////////////////////////////////
   // head entry toward the engine

   assign cyc_valid     = count != '0;
   assign cyc_req       = mem[rd_ptr];
   assign credit_return = pop;   // slot freed, hand the credit back

endmodule

`default_nettype wire

// File: ide/ide_cycle.sv
/*
 * IDE PIO cycle engine: setup, strobe, done and two recovery states,
 * read data return and ATA status decode into a device error flag
 */
`timescale 1ns/1ps
`default_nettype none

module ide_cycle
   import ata_pkg::*, host_pkg::*;
#(
   parameter logic [3:0] strobe_cycles = 4'd15  // extra cycles with the strobe low
) (
   input  logic        clk,
   input  logic        reset,

   input  logic        cyc_valid,
   input  ide_req_t    cyc_req,
   output logic        cyc_take,

   output logic        rsp_valid,
   output ide_rsp_t    rsp,
   output logic        device_error,

   input  logic [15:0] ide_data_in,
   output logic [15:0] ide_data_out,
   output logic        ide_dior,
   output logic        ide_diow,
   output logic [1:0]  ide_cs,
   output logic [2:0]  ide_da
);

   localparam logic [2:0] st_idle   = 3'd0;
   localparam logic [2:0] st_setup  = 3'd1;
   localparam logic [2:0] st_strobe = 3'd2;
   localparam logic [2:0] st_done   = 3'd3;
   localparam logic [2:0] st_rec1   = 3'd4;
   localparam logic [2:0] st_rec2   = 3'd5;

   logic [2:0]  state;
   logic [2:0]  state_next;
   logic [3:0]  strobe_count;
   logic [15:0] data_in_q;      // bus data, one cycle behind the pins
   ide_req_t    cur;            // request owned for the whole bus cycle
   ata_word_u   rdata_q;
   logic        cycle_active;
   logic        strobe_active;
   logic        last_strobe;
   logic        status_read;

   //////////////////////////////////////////////////
   // sequencer

   assign cycle_active  = state != st_idle;
   assign strobe_active = state == st_strobe;
   assign last_strobe   = strobe_active && (strobe_count == strobe_cycles);
   assign cyc_take      = (state == st_idle) && cyc_valid;

   always_comb begin
      state_next = state;
      case (state)
         st_idle:   if (cyc_valid) state_next = st_setup;
         st_setup:  state_next = st_strobe;
         st_strobe: if (last_strobe) state_next = st_done;
         st_done:   state_next = st_rec1;
         st_rec1:   state_next = st_rec2;
         st_rec2:   state_next = st_idle;
         default:   state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= st_idle;
      else
         state <= state_next;
   end

   // counts strobe cycles, restarted from setup
   always_ff @(posedge clk) begin
      if (reset)
         strobe_count <= 4'd0;
      else if (state == st_setup)
         strobe_count <= 4'd0;
      else if (strobe_active)
         strobe_count <= strobe_count + 4'd1;
   end

   //////////////////////////////////////////////////
   // datapath

   always_ff @(posedge clk) begin
      data_in_q <= ide_data_in;
      if (cyc_take)
         cur <= cyc_req;
      if (last_strobe && !cur.write)
         rdata_q.raw <= data_in_q;   // sample late in the strobe
   end

   // address, chip selects and write data held from setup through rec2
   assign ide_cs       = cycle_active ? cur.addr.cs : ata_idle_addr.cs;
   assign ide_da       = cycle_active ? cur.addr.da : ata_idle_addr.da;
   assign ide_data_out = (cycle_active && cur.write) ? cur.wdata : 16'h0000;

   assign ide_dior = ~(strobe_active && !cur.write);
   assign ide_diow = ~(strobe_active && cur.write);

   //////////////////////////////////////////////////
   // response and status decode

   assign rsp_valid  = (state == st_done) && !cur.write;
   assign rsp.addr   = cur.addr;
   assign rsp.rdata  = rdata_q;

   assign status_read = !cur.write && (cur.addr == ata_status_addr);

   // err bit sticks until the next status read
   always_ff @(posedge clk) begin
      if (reset)
         device_error <= 1'b0;
      else if ((state == st_done) && status_read)
         device_error <= rdata_q.status.err;
   end

endmodule

`default_nettype wire

// File: common/host_pkg.sv
/*
 * host-side request and response structs
 */
`default_nettype none

package host_pkg;

   import ata_pkg::*;

   // one register access from the host, 22 bits
   typedef struct packed {
      logic        write;  // 1 = write, 0 = read
      ata_addr_t   addr;
      logic [15:0] wdata;
   } ide_req_t;

   // read response back to the host, 21 bits
   typedef struct packed {
      ata_addr_t addr;
      ata_word_u rdata;
   } ide_rsp_t;

endpackage

`default_nettype wire

// File: common/ata_pkg.sv
/*
 * ATA device-side types: task-file address, status register bits,
 * and the union that reads one bus word as data or as status
 */
`default_nettype none

package ata_pkg;

   // task-file address as driven onto the cable
   typedef struct packed {
      logic [1:0] cs;   // chip selects, active low
      logic [2:0] da;   // device address lines
   } ata_addr_t;

   // ATA status register, low byte only carries bits
   typedef struct packed {
      logic [7:0] unused;
      logic       bsy;   // device busy
      logic       drdy;  // device ready
      logic       df;    // device fault
      logic       dsc;   // seek complete
      logic       drq;   // data request
      logic       corr;  // corrected data
      logic       idx;   // index mark
      logic       err;   // error in previous command
   } ata_status_t;

   // same 16 bits, read either as raw data or as status
   typedef union packed {
      logic [15:0] raw;
      ata_status_t status;
   } ata_word_u;

   ///////////////////////////////////////////////////
   // fixed addresses
   localparam ata_addr_t ata_status_addr = '{cs: 2'b10, da: 3'b111};
   localparam ata_addr_t ata_idle_addr   = '{cs: 2'b11, da: 3'b111};  // bus parked

endpackage

`default_nettype wire
